/* run.sh */
#!/bin/sh
# build and run the write engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module write_engine_tb \
	-f vlog.f -o write_engine_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/write_engine_sim > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src/data_pair_buffer.sv */
////////////////////
// two line FIFOs moved in lock-step, one per half line
// the low side also carries the offset and element count
////////////////////
`timescale 1ns/100ps

module data_pair_buffer import wr_cmd_pkg::*; #(
	parameter int BUFFER_DEPTH    = 16,
	parameter int BUFFER_HEADROOM = 4
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   data_valid,
	input  logic [LINE_BITS-1:0]   data_lo,
	input  logic [LINE_BITS-1:0]   data_hi,
	input  logic [OFFSET_BITS-1:0] data_offset,
	input  logic [ELEM_BITS-1:0]   data_elems,
	input  logic                   pop,
	output logic                   head_valid,
	output logic [LINE_BITS-1:0]   head_lo,
	output logic [LINE_BITS-1:0]   head_hi,
	output logic [OFFSET_BITS-1:0] head_offset,
	output logic [ELEM_BITS-1:0]   head_elems,
	output logic                   buffer_almost_full
);

	localparam int LO_BITS = LINE_BITS + OFFSET_BITS + ELEM_BITS;

	logic               push;
	logic               pop_pair;
	logic               lo_full;
	logic               hi_full;
	logic               lo_valid;
	logic               hi_valid;
	logic [LO_BITS-1:0] lo_head;

	// a pair goes in only when both sides have room
	assign push     = data_valid && !lo_full && !hi_full;
	assign pop_pair = pop && head_valid;

	assign head_valid = lo_valid && hi_valid;
	assign {head_lo, head_offset, head_elems} = lo_head;

	line_fifo #(
		.WIDTH   (LO_BITS),
		.DEPTH   (BUFFER_DEPTH),
		.HEADROOM(BUFFER_HEADROOM)
	) lo_fifo_i (
		.clock      (clock),
		.rstn       (rstn),
		.push       (push),
		.data_in    ({data_lo, data_offset, data_elems}),
		.pop        (pop_pair),
		.data_out   (lo_head),
		.valid      (lo_valid),
		.full       (lo_full),
		.almost_full(buffer_almost_full),
		.empty      ()
	);

	// high half only, flags follow the low side
	line_fifo #(
		.WIDTH   (LINE_BITS),
		.DEPTH   (BUFFER_DEPTH),
		.HEADROOM(BUFFER_HEADROOM)
	) hi_fifo_i (
		.clock      (clock),
		.rstn       (rstn),
		.push       (push),
		.data_in    (data_hi),
		.pop        (pop_pair),
		.data_out   (head_hi),
		.valid      (hi_valid),
		.full       (hi_full),
		.almost_full(),
		.empty      ()
	);

endmodule

/* src/line_fifo.sv */
////////////////////
// show-ahead FIFO, head word visible on data_out while valid
// almost_full rises when free space drops to HEADROOM or less
////////////////////
`timescale 1ns/100ps

module line_fifo #(
	parameter int WIDTH    = 64,
	parameter int DEPTH    = 16,
	parameter int HEADROOM = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// overflow and underflow are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	assign data_out    = mem[rd_ptr];
	assign empty       = (count == '0);
	assign valid       = !empty;
	assign full        = (count == CNT_BITS'(DEPTH));
	assign almost_full = (count >= CNT_BITS'(DEPTH - HEADROOM));

endmodule

/* src/wr_cmd_pkg.sv */
////////////////////
// write command encodings, field widths and the byte size rule
// shared by the write engine and its testbench
////////////////////

package wr_cmd_pkg;

	// one half of a 128 byte cache line
	localparam int LINE_BITS     = 512;
	localparam int ADDR_BITS     = 64;
	localparam int OFFSET_BITS   = 32;
	localparam int ELEM_BITS     = 32;
	localparam int ELEM_BYTES    = 4;
	localparam int CMD_SIZE_BITS = 12;

	// write opcodes as seen by the memory side
	typedef enum logic [12:0] {
		WRITE_NA = 13'h0D00,
		WRITE_MS = 13'h0D70
	} write_opcode;

	// bytes moved by a command carrying elems elements
	function automatic logic [CMD_SIZE_BITS-1:0] cmd_bytes(input logic [ELEM_BITS-1:0] elems);
		return CMD_SIZE_BITS'(elems * ELEM_BYTES);
	endfunction

endpackage

/* src/wr_stream_pkg.sv */
////////////////////
// states of the write stream machine
////////////////////

package wr_stream_pkg;

	// STREAM_RESET only passes through to idle
	typedef enum logic [2:0] {
		STREAM_RESET,
		STREAM_IDLE,
		STREAM_START,
		STREAM_REQ,
		STREAM_PENDING,
		STREAM_DONE
	} write_state;

endpackage

/* src/write_engine.sv */
////////////////////
// write engine top, pair buffer feeding the stream machine
// buffer and batch sizes are set here
////////////////////
`timescale 1ns/100ps

module write_engine import wr_cmd_pkg::*; #(
	parameter int BUFFER_DEPTH    = 16,
	parameter int BUFFER_HEADROOM = 4,
	parameter int MAX_BATCH       = 8
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     job_valid,
	input  logic [ADDR_BITS-1:0]     job_base,
	input  logic [ELEM_BITS-1:0]     job_elems,
	input  logic                     data_valid,
	input  logic [LINE_BITS-1:0]     data_lo,
	input  logic [LINE_BITS-1:0]     data_hi,
	input  logic [OFFSET_BITS-1:0]   data_offset,
	input  logic [ELEM_BITS-1:0]     data_elems,
	input  logic                     ms_mode,
	input  logic                     cmd_almost_full,
	input  logic                     resp_valid,
	input  logic [ELEM_BITS-1:0]     resp_elems,
	output logic                     buffer_almost_full,
	output logic                     cmd_valid,
	output write_opcode              cmd_opcode,
	output logic [ADDR_BITS-1:0]     cmd_addr,
	output logic [CMD_SIZE_BITS-1:0] cmd_size,
	output logic [LINE_BITS-1:0]     out_lo,
	output logic [LINE_BITS-1:0]     out_hi,
	output logic [ELEM_BITS-1:0]     done_elems,
	output logic                     job_done
);

	// buffer head to the stream machine
	logic                   head_valid;
	logic [LINE_BITS-1:0]   head_lo;
	logic [LINE_BITS-1:0]   head_hi;
	logic [OFFSET_BITS-1:0] head_offset;
	logic [ELEM_BITS-1:0]   head_elems;
	logic                   pop;

	data_pair_buffer #(
		.BUFFER_DEPTH   (BUFFER_DEPTH),
		.BUFFER_HEADROOM(BUFFER_HEADROOM)
	) buffer_i (
		.clock             (clock),
		.rstn              (rstn),
		.data_valid        (data_valid),
		.data_lo           (data_lo),
		.data_hi           (data_hi),
		.data_offset       (data_offset),
		.data_elems        (data_elems),
		.pop               (pop),
		.head_valid        (head_valid),
		.head_lo           (head_lo),
		.head_hi           (head_hi),
		.head_offset       (head_offset),
		.head_elems        (head_elems),
		.buffer_almost_full(buffer_almost_full)
	);

	write_stream_fsm #(
		.MAX_BATCH(MAX_BATCH)
	) stream_i (
		.clock          (clock),
		.rstn           (rstn),
		.job_valid      (job_valid),
		.job_base       (job_base),
		.job_elems      (job_elems),
		.ms_mode        (ms_mode),
		.cmd_almost_full(cmd_almost_full),
		.head_valid     (head_valid),
		.head_lo        (head_lo),
		.head_hi        (head_hi),
		.head_offset    (head_offset),
		.head_elems     (head_elems),
		.resp_valid     (resp_valid),
		.resp_elems     (resp_elems),
		.pop            (pop),
		.cmd_valid      (cmd_valid),
		.cmd_opcode     (cmd_opcode),
		.cmd_addr       (cmd_addr),
		.cmd_size       (cmd_size),
		.out_lo         (out_lo),
		.out_hi         (out_hi),
		.done_elems     (done_elems),
		.job_done       (job_done)
	);

endmodule

/* src/write_stream_fsm.sv */
////////////////////
// write stream control: job latch, batches, command registers
// and the running count of written elements
////////////////////
`timescale 1ns/100ps

module write_stream_fsm import wr_cmd_pkg::*, wr_stream_pkg::*; #(
	parameter int MAX_BATCH = 8
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     job_valid,
	input  logic [ADDR_BITS-1:0]     job_base,
	input  logic [ELEM_BITS-1:0]     job_elems,
	input  logic                     ms_mode,
	input  logic                     cmd_almost_full,
	input  logic                     head_valid,
	input  logic [LINE_BITS-1:0]     head_lo,
	input  logic [LINE_BITS-1:0]     head_hi,
	input  logic [OFFSET_BITS-1:0]   head_offset,
	input  logic [ELEM_BITS-1:0]     head_elems,
	input  logic                     resp_valid,
	input  logic [ELEM_BITS-1:0]     resp_elems,
	output logic                     pop,
	output logic                     cmd_valid,
	output write_opcode              cmd_opcode,
	output logic [ADDR_BITS-1:0]     cmd_addr,
	output logic [CMD_SIZE_BITS-1:0] cmd_size,
	output logic [LINE_BITS-1:0]     out_lo,
	output logic [LINE_BITS-1:0]     out_hi,
	output logic [ELEM_BITS-1:0]     done_elems,
	output logic                     job_done
);

	localparam int BATCH_BITS = $clog2(MAX_BATCH + 1);

	write_state            state;
	write_state            next_state;
	logic [ADDR_BITS-1:0]  base_addr;
	logic [ELEM_BITS-1:0]  remaining;
	logic [BATCH_BITS-1:0] sent_count;
	logic [BATCH_BITS-1:0] resp_count;
	logic                  batch_full;
	logic                  job_empty;

	// two slots of slack for the command in flight
	assign batch_full = (sent_count >= BATCH_BITS'(MAX_BATCH - 2));
	assign job_empty  = (remaining == '0);

	////////////////////
	// state machine
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= STREAM_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			STREAM_RESET: begin
				next_state = STREAM_IDLE;
			end
			STREAM_IDLE: begin
				if (job_valid) begin
					next_state = STREAM_START;
				end
			end
			STREAM_START: begin
				next_state = STREAM_REQ;
			end
			STREAM_REQ: begin
				if (batch_full || job_empty) begin
					next_state = STREAM_PENDING;
				end
			end
			STREAM_PENDING: begin
				// whole batch answered
				if (resp_count == sent_count) begin
					next_state = STREAM_DONE;
				end
			end
			STREAM_DONE: begin
				next_state = job_empty ? STREAM_IDLE : STREAM_START;
			end
			default: begin
				next_state = STREAM_IDLE;
			end
		endcase
	end

	// never pop on the cycle the machine leaves REQ
	assign pop = (state == STREAM_REQ) && (next_state == STREAM_REQ) &&
		head_valid && !cmd_almost_full;

	////////////////////
	// job and batch counters
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining  <= '0;
			sent_count <= '0;
			resp_count <= '0;
		end else begin
			case (state)
				STREAM_IDLE: begin
					if (job_valid) begin
						remaining <= job_elems;
					end
				end
				STREAM_START: begin
					sent_count <= '0;
					resp_count <= '0;
				end
				STREAM_REQ, STREAM_PENDING: begin
					if (pop) begin
						sent_count <= sent_count + 1'b1;
						// saturate on a short last pair
						remaining <= (head_elems >= remaining) ? '0 : remaining - head_elems;
					end
					if (resp_valid) begin
						resp_count <= resp_count + 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state == STREAM_IDLE) && job_valid) begin
			base_addr <= job_base;
		end
	end

	////////////////////
	// output registers
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid  <= 1'b0;
			job_done   <= 1'b0;
			done_elems <= '0;
		end else begin
			cmd_valid <= pop;
			job_done  <= (state == STREAM_DONE) && job_empty;
			if (resp_valid) begin
				done_elems <= done_elems + resp_elems;
			end
		end
	end

	// command payload, loaded with each popped pair
	always_ff @(posedge clock) begin
		if (pop) begin
			cmd_opcode <= ms_mode ? WRITE_MS : WRITE_NA;
			cmd_addr   <= base_addr + ADDR_BITS'(head_offset);
			cmd_size   <= cmd_bytes(head_elems);
			out_lo     <= head_lo;
			out_hi     <= head_hi;
		end
	end

endmodule

/* tests/write_engine_chk.sv */
////////////////////
// concurrent checks on the write engine ports, bound to the top level
////////////////////
`timescale 1ns/100ps

module write_engine_chk (
	input logic clock,
	input logic rstn,
	input logic cmd_valid,
	input logic job_done,
	input logic cmd_almost_full
);

	// command strobe always driven out of reset
	cmd_known: assert property (
		@(posedge clock) disable iff (!rstn) !$isunknown(cmd_valid)
	) else $error("cmd_valid is unknown after reset");

	job_done_pulse: assert property (
		@(posedge clock) disable iff (!rstn) job_done |=> !job_done
	) else $error("job_done stayed high for more than one cycle");

	// only the command already registered may follow the rise
	hold_stops_commands: assert property (
		@(posedge clock) disable iff (!rstn)
		(cmd_almost_full && $past(cmd_almost_full)) |-> !cmd_valid
	) else $error("command issued while cmd_almost_full was held high");

endmodule

bind write_engine write_engine_chk chk_i (.*);

/* tests/write_engine_tb.sv */
////////////////////
// write engine testbench, applies a job table row by row
// with a memory response model and back-pressure patterns
////////////////////
`timescale 1ns/100ps

module write_engine_tb import wr_cmd_pkg::*, wr_stream_pkg::*; ();

	localparam int BUFFER_DEPTH    = 16;
	localparam int BUFFER_HEADROOM = 4;
	localparam int MAX_BATCH       = 8;
	localparam int NUM_ROWS        = 5;

	// pair element counts are nibbles of elem_seq plus one, used in turn
	typedef struct packed {
		logic [ADDR_BITS-1:0] base;
		logic [7:0]           pairs;
		logic [31:0]          elem_seq;
		logic                 ms;
		logic [7:0]           delay;
		logic [15:0]          bp;
	} job_row;

	job_row jobs [NUM_ROWS] = '{
		'{64'h0000_1000_0000_0000, 8'd4,  32'h3821_F7A5, 1'b0, 8'd3,  16'h0000},
		'{64'h0000_0000_8000_0040, 8'd6,  32'hFFFF_FFFF, 1'b1, 8'd5,  16'h0000},
		// long response delay, several batches
		'{64'h0000_0042_0000_0000, 8'd14, 32'h0123_4567, 1'b0, 8'd30, 16'h0000},
		'{64'h0000_0007_FFF0_0000, 8'd10, 32'h9A5C_3E71, 1'b1, 8'd2,  16'h0F0F},
		'{64'h0000_1234_5678_0000, 8'd20, 32'h7654_3210, 1'b0, 8'd6,  16'h7E00}
	};

	logic                     clock;
	logic                     rstn;
	logic                     job_valid;
	logic [ADDR_BITS-1:0]     job_base;
	logic [ELEM_BITS-1:0]     job_elems;
	logic                     data_valid;
	logic [LINE_BITS-1:0]     data_lo;
	logic [LINE_BITS-1:0]     data_hi;
	logic [OFFSET_BITS-1:0]   data_offset;
	logic [ELEM_BITS-1:0]     data_elems;
	logic                     ms_mode;
	logic                     cmd_almost_full;
	logic                     resp_valid;
	logic [ELEM_BITS-1:0]     resp_elems;
	logic                     buffer_almost_full;
	logic                     cmd_valid;
	write_opcode              cmd_opcode;
	logic [ADDR_BITS-1:0]     cmd_addr;
	logic [CMD_SIZE_BITS-1:0] cmd_size;
	logic [LINE_BITS-1:0]     out_lo;
	logic [LINE_BITS-1:0]     out_hi;
	logic [ELEM_BITS-1:0]     done_elems;
	logic                     job_done;

	// expected commands in push order, pending responses by due cycle
	logic [ADDR_BITS-1:0]     exp_addr [$];
	logic [CMD_SIZE_BITS-1:0] exp_size [$];
	write_opcode              exp_op [$];
	logic [LINE_BITS-1:0]     exp_lo [$];
	logic [LINE_BITS-1:0]     exp_hi [$];
	int                       exp_elems [$];
	int                       resp_due [$];
	int                       resp_count [$];

	logic [31:0]          lcg_state = 32'd92151;
	logic [ELEM_BITS-1:0] exp_done = '0;
	logic [15:0]          bp_pattern = '0;
	logic                 bp_level;
	int                   cycle_count = 0;
	int                   errors = 0;
	int                   in_flight = 0;
	int                   held_cmds = 0;
	int                   job_count = 0;
	int                   cmd_total = 0;
	int                   resp_delay = 0;
	int                   buffered = 0;
	int                   push_seen = 0;

	write_engine #(
		.BUFFER_DEPTH   (BUFFER_DEPTH),
		.BUFFER_HEADROOM(BUFFER_HEADROOM),
		.MAX_BATCH      (MAX_BATCH)
	) dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [LINE_BITS-1:0] random_line();
		logic [LINE_BITS-1:0] line;
		for (int w = 0; w < LINE_BITS / 32; w++) begin
			line[w*32 +: 32] = next_random();
		end
		return line;
	endfunction

	function automatic int pair_elems(input int r, input int i);
		return int'(jobs[r].elem_seq[(i % 8) * 4 +: 4]) + 1;
	endfunction

	task automatic drive_step();
		@(posedge clock);
		#2;
	endtask

	// one pair onto the data port, held back while the buffer is nearly full
	task automatic push_pair(input int r, input int i);
		logic [OFFSET_BITS-1:0] offset;
		int                     elems;
		if (buffer_almost_full) begin
			data_valid = 1'b0;
			while (buffer_almost_full) begin
				drive_step();
			end
		end
		offset = next_random() & 32'h000F_FFC0;
		elems = pair_elems(r, i);
		data_valid = 1'b1;
		data_lo = random_line();
		data_hi = random_line();
		data_offset = offset;
		data_elems = ELEM_BITS'(elems);
		exp_addr.push_back(jobs[r].base + ADDR_BITS'(offset));
		exp_size.push_back(CMD_SIZE_BITS'(elems * ELEM_BYTES));
		exp_op.push_back(jobs[r].ms ? WRITE_MS : WRITE_NA);
		exp_lo.push_back(data_lo);
		exp_hi.push_back(data_hi);
		exp_elems.push_back(elems);
		drive_step();
	endtask

	task automatic check_command();
		if (exp_addr.size() == 0) begin
			$display("ERROR at %0t: command issued with no pushed pair waiting", $time);
			errors++;
		end else begin
			assert (cmd_addr == exp_addr[0] && cmd_size == exp_size[0] &&
				cmd_opcode == exp_op[0] && out_lo == exp_lo[0] && out_hi == exp_hi[0])
			else begin
				$display(
					"MISMATCH at %0t: command %0d addr %h/%h size %0d/%0d op %h/%h data %0s",
					$time, cmd_total, cmd_addr, exp_addr[0], cmd_size, exp_size[0],
					cmd_opcode, exp_op[0],
					(out_lo == exp_lo[0] && out_hi == exp_hi[0]) ? "ok" : "bad");
				errors++;
			end
			resp_due.push_back(cycle_count + resp_delay);
			resp_count.push_back(exp_elems[0]);
			void'(exp_addr.pop_front());
			void'(exp_size.pop_front());
			void'(exp_op.pop_front());
			void'(exp_lo.pop_front());
			void'(exp_hi.pop_front());
			void'(exp_elems.pop_front());
		end
		cmd_total++;
		in_flight++;
		assert (in_flight <= MAX_BATCH) else begin
			$display("ERROR at %0t: %0d commands unanswered, more than a batch", $time, in_flight);
			errors++;
		end
	endtask

	////////////////////
	// monitor, sampled mid-cycle
	////////////////////

	always @(negedge clock) begin
		if (rstn) begin
			if (cmd_valid) begin
				check_command();
			end
			// pairs held after the last edge, a command marks a pop at that edge
			buffered = buffered + push_seen - (cmd_valid ? 1 : 0);
			assert (buffer_almost_full == ((BUFFER_DEPTH - buffered) <= BUFFER_HEADROOM))
			else begin
				$display("MISMATCH at %0t: buffer_almost_full %0b with %0d pairs buffered",
					$time, buffer_almost_full, buffered);
				errors++;
			end
			push_seen = data_valid ? 1 : 0;
			if (cmd_almost_full) begin
				if (cmd_valid) begin
					held_cmds++;
				end
				assert (held_cmds <= 1) else begin
					$display("ERROR at %0t: commands kept coming under back-pressure", $time);
					errors++;
				end
			end else begin
				held_cmds = 0;
			end
			assert (done_elems == exp_done) else begin
				$display("MISMATCH at %0t: done_elems %0d, expected %0d",
					$time, done_elems, exp_done);
				errors++;
			end
			// counted by the DUT at the next edge
			if (resp_valid) begin
				exp_done = exp_done + resp_elems;
				in_flight--;
			end
			if (job_done) begin
				job_count++;
			end
		end
	end

	// memory model, one response per cycle once due
	initial begin
		forever begin
			@(posedge clock);
			#2;
			if (resp_due.size() > 0 && resp_due[0] <= cycle_count) begin
				resp_valid = 1'b1;
				resp_elems = ELEM_BITS'(resp_count.pop_front());
				void'(resp_due.pop_front());
			end else begin
				resp_valid = 1'b0;
			end
		end
	end

	// back-pressure follows the row pattern by cycle
	initial begin
		forever begin
			@(negedge clock);
			bp_level = bp_pattern[cycle_count % 16];
			@(posedge clock);
			#2;
			cmd_almost_full = bp_level;
		end
	end

	initial begin
		int limit;
		limit = 100;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += jobs[r].pairs * (jobs[r].delay + 10);
		end
		repeat (limit) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("ERRORS FOUND");
		$finish;
	end

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int row_total;
		int all_total;
		int row_errors;
		all_total = 0;
		rstn = 1'b0;
		job_valid = 1'b0;
		job_base = '0;
		job_elems = '0;
		data_valid = 1'b0;
		data_lo = '0;
		data_hi = '0;
		data_offset = '0;
		data_elems = '0;
		ms_mode = 1'b0;
		cmd_almost_full = 1'b0;
		resp_valid = 1'b0;
		resp_elems = '0;
		repeat (2) @(posedge clock);
		#2;
		rstn = 1'b1;
		drive_step();
		assert (!cmd_valid && !job_done && !dut_i.pop && done_elems == '0 &&
			dut_i.stream_i.state == STREAM_IDLE)
		else begin
			$display("ERROR at %0t: outputs or state not cleared by reset", $time);
			errors++;
		end
		$display("reset check finished, errors %0d", errors);

		for (int r = 0; r < NUM_ROWS; r++) begin
			row_errors = errors;
			row_total = 0;
			for (int i = 0; i < jobs[r].pairs; i++) begin
				row_total += pair_elems(r, i);
			end
			resp_delay = jobs[r].delay;
			bp_pattern = jobs[r].bp;
			ms_mode = jobs[r].ms;
			job_valid = 1'b1;
			job_base = jobs[r].base;
			job_elems = ELEM_BITS'(row_total);
			drive_step();
			job_valid = 1'b0;
			for (int i = 0; i < jobs[r].pairs; i++) begin
				push_pair(r, i);
			end
			data_valid = 1'b0;
			while (job_count <= r) begin
				drive_step();
			end
			all_total += row_total;
			assert (done_elems == ELEM_BITS'(all_total)) else begin
				$display("MISMATCH at %0t: done_elems %0d at job end, expected %0d",
					$time, done_elems, all_total);
				errors++;
			end
			assert (job_count == r + 1 && exp_addr.size() == 0 && resp_due.size() == 0)
			else begin
				$display("ERROR at %0t: job %0d ended with pairs or responses left over", $time, r);
				errors++;
			end
			$display("row %0d finished: %0d pairs, %0d elements, ms_mode %0d, errors %0d",
				r, jobs[r].pairs, row_total, jobs[r].ms, errors - row_errors);
		end
		bp_pattern = '0;

		$display("rows %0d, commands %0d, jobs done %0d, errors %0d",
			NUM_ROWS, cmd_total, job_count, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* vlog.f */
src/wr_cmd_pkg.sv
src/wr_stream_pkg.sv
src/line_fifo.sv
src/data_pair_buffer.sv
src/write_stream_fsm.sv
src/write_engine.sv
tests/write_engine_chk.sv
tests/write_engine_tb.sv
